//--- logic/angle_pkg.sv
// ==========================================================
// angle package
// yaw angle formats, heading range and PI gain constants
// ==========================================================
`default_nettype none

package angle_pkg;

	// angle and error values, two's complement, 1/16 degree
	localparam int angle_w = 16;

	// tracked heading, quarter units of 1/16 degree
	localparam int track_w = 32;

	// angle landmarks in 1/16 degree
	localparam logic signed [angle_w-1:0] angle_360 = 16'sd5760;
	localparam logic signed [angle_w-1:0] angle_270 = 16'sd4320;
	localparam logic signed [angle_w-1:0] angle_90  = 16'sd1440;
	localparam logic signed [angle_w-1:0] angle_0   = 16'sd0;

	// full turn of the tracked heading (4x angle_360)
	localparam logic signed [track_w-1:0] track_360 = 32'sd23040;

	// PI gains as arithmetic right shifts
	localparam int kp_shift = 2;
	localparam int ki_shift = 4;

	// integral clamp magnitude
	localparam int integ_limit = 8192;

	// rate command saturation, full 16 bit range
	localparam int rate_max = 32767;

endpackage

`default_nettype wire

//--- logic/receiver_pkg.sv
// ==========================================================
// receiver package
// stick value width, yaw stick center and idle throttle level
// ==========================================================
`default_nettype none

package receiver_pkg;

	// receiver values run 0..250
	localparam int rx_w = 8;

	// yaw stick rest position
	localparam logic [rx_w-1:0] stick_center = 8'd125;

	// throttle below this is treated as motors idle
	localparam logic [rx_w-1:0] idle_throttle = 8'd10;

endpackage

`default_nettype wire

//--- logic/control_frame_sequencer.sv
// ==========================================================
// control frame sequencer
// takes one receiver sample at a time, holds it with the IMU
// angle and starts a frame; waits for the command handoff
// ==========================================================
`default_nettype none

module control_frame_sequencer (
	input  wire                                      us_clk,
	input  wire                                      resetn,
	input  wire                                      rx_valid,
	input  wire        [receiver_pkg::rx_w-1:0]      throttle,
	input  wire        [receiver_pkg::rx_w-1:0]      yaw_stick,
	input  wire signed [angle_pkg::angle_w-1:0]      imu_yaw,
	output logic                                     rx_ready,
	input  wire                                      cmd_taken,
	output logic                                     frame_start,
	output logic       [receiver_pkg::rx_w-1:0]      frame_throttle,
	output logic       [receiver_pkg::rx_w-1:0]      frame_yaw_stick,
	output logic signed [angle_pkg::angle_w-1:0]     frame_imu_yaw
);

	logic busy; // a frame is in flight
	logic accept;

	assign rx_ready = ~busy;
	assign accept   = rx_valid & rx_ready;

	// frame control
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			busy        <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			frame_start <= accept; // single pulse, busy blocks a second accept
			if (accept)
				busy <= 1'b1;
			else if (cmd_taken)
				busy <= 1'b0; // ready again the cycle after the handoff
		end
	end

	// frame inputs, held until the next accept
	always_ff @(posedge us_clk) begin
		if (accept) begin
			frame_throttle  <= throttle;
			frame_yaw_stick <= yaw_stick;
			frame_imu_yaw   <= imu_yaw; // sampled on the same edge as the rx transfer
		end
	end

	// only one frame may be in flight
	a_start_when_idle: assert property (
		@(posedge us_clk) disable iff (!resetn)
		frame_start |-> $past(!busy)
	);

endmodule

`default_nettype wire

//--- logic/yaw_angle_accumulator.sv
// ==========================================================
// yaw angle accumulator
// integrates the yaw stick into a tracked heading and forms
// the heading error against the IMU, wrapped at 0/360 deg
// ==========================================================
`default_nettype none

module yaw_angle_accumulator (
	input  wire                                      us_clk,
	input  wire                                      resetn,
	input  wire                                      frame_start,
	input  wire        [receiver_pkg::rx_w-1:0]      frame_throttle,
	input  wire        [receiver_pkg::rx_w-1:0]      frame_yaw_stick,
	input  wire signed [angle_pkg::angle_w-1:0]      frame_imu_yaw,
	output logic                                     active,
	output logic                                     frame_done,
	output logic signed [angle_pkg::angle_w-1:0]     body_yaw,
	output logic signed [angle_pkg::angle_w-1:0]     yaw_error,
	output logic                                     throttle_idle
);

	import angle_pkg::*;
	import receiver_pkg::*;

	// one-hot states
	localparam logic [4:0] st_waiting  = 5'b00001;
	localparam logic [4:0] st_track    = 5'b00010;
	localparam logic [4:0] st_target   = 5'b00100;
	localparam logic [4:0] st_error    = 5'b01000;
	localparam logic [4:0] st_complete = 5'b10000;

	logic [4:0] state, next_state;

	logic signed [track_w-1:0] heading;     // quarter units
	logic signed [track_w-1:0] stick_off;
	logic signed [track_w-1:0] track_sum;
	logic signed [track_w-1:0] track_next;
	logic signed [track_w-1:0] imu_track;

	assign throttle_idle = frame_throttle < idle_throttle;
	assign active        = ~state[0]; // anything past waiting

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= st_waiting;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			st_waiting:  next_state = frame_start ? st_track : st_waiting;
			st_track:    next_state = st_target;
			st_target:   next_state = st_error;
			st_error:    next_state = st_complete;
			st_complete: next_state = st_waiting;
			default:     next_state = st_waiting;
		endcase
	end

	// stick offset around center, zero-extended before the subtract
	assign stick_off = $signed({{(track_w-rx_w){1'b0}}, frame_yaw_stick})
		- $signed({{(track_w-rx_w){1'b0}}, stick_center});
	assign track_sum = heading + stick_off;
	assign imu_track = track_w'(frame_imu_yaw) <<< 2;

	// keep the heading inside one turn
	always_comb begin
		if (track_sum > track_360)
			track_next = track_sum - track_360;
		else if (track_sum < angle_0)
			track_next = track_sum + track_360;
		else
			track_next = track_sum;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			heading    <= '0;
			body_yaw   <= angle_0;
			yaw_error  <= angle_0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= (state == st_complete);
			case (state)
				st_track: begin
					if (throttle_idle)
						heading <= imu_track; // motors idle, follow the IMU
					else
						heading <= track_next;
				end
				st_target: begin
					if (throttle_idle)
						body_yaw <= frame_imu_yaw;
					else
						body_yaw <= angle_w'(heading >>> 2); // back to 1/16 degree
				end
				st_error: begin
					if (throttle_idle)
						yaw_error <= angle_0;
					else if (body_yaw > angle_270 && frame_imu_yaw < angle_90)
						yaw_error <= (angle_360 - body_yaw) + frame_imu_yaw; // across 360 upward
					else if (frame_imu_yaw > angle_270 && body_yaw < angle_90)
						yaw_error <= (frame_imu_yaw - angle_360) - body_yaw; // across 0 downward
					else
						yaw_error <= body_yaw - frame_imu_yaw;
				end
				default: ;
			endcase
		end
	end

	// done is a single pulse per frame
	a_done_pulse: assert property (
		@(posedge us_clk) disable iff (!resetn)
		frame_done |=> !frame_done
	);

	// the sequencer must not start a new frame mid-calculation
	a_no_start_active: assert property (
		@(posedge us_clk) disable iff (!resetn)
		frame_start |-> !active
	);

endmodule

`default_nettype wire

//--- logic/yaw_rate_controller.sv
// ==========================================================
// yaw rate controller
// PI stage on the heading error, saturated rate command
// presented on a valid/ready output
// ==========================================================
`default_nettype none

module yaw_rate_controller (
	input  wire                                      us_clk,
	input  wire                                      resetn,
	input  wire                                      frame_done,
	input  wire signed [angle_pkg::angle_w-1:0]      yaw_error,
	input  wire                                      throttle_idle,
	input  wire                                      cmd_ready,
	output logic                                     cmd_valid,
	output logic signed [angle_pkg::angle_w-1:0]     yaw_rate_cmd,
	output logic                                     cmd_taken
);

	import angle_pkg::*;

	// headroom for the unclamped sums
	localparam int sum_w = angle_w + 2;

	logic signed [angle_w-1:0] integ;
	logic signed [angle_w-1:0] integ_next;
	logic signed [sum_w-1:0]   err_ext;
	logic signed [sum_w-1:0]   integ_sum;
	logic signed [sum_w-1:0]   cmd_sum;
	logic signed [angle_w-1:0] cmd_sat;

	assign cmd_taken = cmd_valid & cmd_ready;

	assign err_ext   = sum_w'(yaw_error);
	assign integ_sum = sum_w'(integ) + err_ext;

	// integral with clamp, cleared when motors idle
	always_comb begin
		if (throttle_idle)
			integ_next = '0;
		else if (integ_sum > integ_limit)
			integ_next = angle_w'(integ_limit);
		else if (integ_sum < -integ_limit)
			integ_next = angle_w'(-integ_limit);
		else
			integ_next = angle_w'(integ_sum);
	end

	assign cmd_sum = (err_ext >>> kp_shift) + (sum_w'(integ_next) >>> ki_shift);

	always_comb begin
		if (cmd_sum > rate_max)
			cmd_sat = angle_w'(rate_max);
		else if (cmd_sum < -rate_max)
			cmd_sat = angle_w'(-rate_max);
		else
			cmd_sat = angle_w'(cmd_sum);
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			integ        <= '0;
			yaw_rate_cmd <= '0;
			cmd_valid    <= 1'b0;
		end else begin
			if (frame_done) begin
				integ        <= integ_next;
				yaw_rate_cmd <= cmd_sat;
				cmd_valid    <= 1'b1;
			end else if (cmd_taken) begin
				cmd_valid <= 1'b0; // command handed off
			end
		end
	end

	// command holds while the consumer stalls
	a_cmd_hold: assert property (
		@(posedge us_clk) disable iff (!resetn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(yaw_rate_cmd)
	);

endmodule

`default_nettype wire

//--- logic/yaw_control_top.sv
// ==========================================================
// yaw control top
// receiver sample in, yaw rate command out, one frame at a time
// ==========================================================
`default_nettype none

module yaw_control_top (
	input  wire                                      us_clk,
	input  wire                                      resetn,
	input  wire                                      rx_valid,
	input  wire        [receiver_pkg::rx_w-1:0]      throttle,
	input  wire        [receiver_pkg::rx_w-1:0]      yaw_stick,
	input  wire signed [angle_pkg::angle_w-1:0]      imu_yaw,
	input  wire                                      cmd_ready,
	output wire                                      rx_ready,
	output wire                                      cmd_valid,
	output wire signed [angle_pkg::angle_w-1:0]      yaw_rate_cmd,
	output wire signed [angle_pkg::angle_w-1:0]      body_yaw,
	output wire signed [angle_pkg::angle_w-1:0]      yaw_error
);

	import angle_pkg::*;
	import receiver_pkg::*;

	wire                      frame_start;
	wire [rx_w-1:0]           frame_throttle;
	wire [rx_w-1:0]           frame_yaw_stick;
	wire signed [angle_w-1:0] frame_imu_yaw;
	wire                      frame_done;
	wire                      throttle_idle;
	wire                      cmd_taken;

	control_frame_sequencer u_sequencer (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.rx_valid        (rx_valid),
		.throttle        (throttle),
		.yaw_stick       (yaw_stick),
		.imu_yaw         (imu_yaw),
		.rx_ready        (rx_ready),
		.cmd_taken       (cmd_taken),
		.frame_start     (frame_start),
		.frame_throttle  (frame_throttle),
		.frame_yaw_stick (frame_yaw_stick),
		.frame_imu_yaw   (frame_imu_yaw)
	);

	yaw_angle_accumulator u_accumulator (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.frame_start     (frame_start),
		.frame_throttle  (frame_throttle),
		.frame_yaw_stick (frame_yaw_stick),
		.frame_imu_yaw   (frame_imu_yaw),
		.active          (), // checked inside the accumulator only
		.frame_done      (frame_done),
		.body_yaw        (body_yaw),
		.yaw_error       (yaw_error),
		.throttle_idle   (throttle_idle)
	);

	yaw_rate_controller u_controller (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.frame_done    (frame_done),
		.yaw_error     (yaw_error),
		.throttle_idle (throttle_idle),
		.cmd_ready     (cmd_ready),
		.cmd_valid     (cmd_valid),
		.yaw_rate_cmd  (yaw_rate_cmd),
		.cmd_taken     (cmd_taken)
	);

endmodule

`default_nettype wire

//--- sim/yaw_control_tb.sv
// ==========================================================
// yaw control testbench
// table driven frames against a heading and PI reference
// model, with cmd_ready stalls and a cycle limit
// ==========================================================
`default_nettype none

module yaw_control_tb;

	import angle_pkg::*;
	import receiver_pkg::*;

	localparam int n_rows          = 21;
	localparam int max_table_stall = 5;
	localparam int max_extra_stall = 3; // two random bits
	localparam int timeout_cycles  =
		n_rows * (6 + max_table_stall + max_extra_stall + 4) + 20;

	logic                      us_clk;
	logic                      resetn;
	logic                      rx_valid;
	logic [rx_w-1:0]           throttle;
	logic [rx_w-1:0]           yaw_stick;
	logic signed [angle_w-1:0] imu_yaw;
	logic                      cmd_ready;
	wire                       rx_ready;
	wire                       cmd_valid;
	wire signed [angle_w-1:0]  yaw_rate_cmd;
	wire signed [angle_w-1:0]  body_yaw;
	wire signed [angle_w-1:0]  yaw_error;

	// row fields: throttle, yaw stick, imu yaw, stall cycles
	logic [39:0] stim_table [0:n_rows-1];

	logic [31:0] lfsr;
	int          model_heading;  // quarter units
	int          model_integ;
	int          cycle_count = 0;

	yaw_control_top u_yaw_control_top (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.rx_valid     (rx_valid),
		.throttle     (throttle),
		.yaw_stick    (yaw_stick),
		.imu_yaw      (imu_yaw),
		.cmd_ready    (cmd_ready),
		.rx_ready     (rx_ready),
		.cmd_valid    (cmd_valid),
		.yaw_rate_cmd (yaw_rate_cmd),
		.body_yaw     (body_yaw),
		.yaw_error    (yaw_error)
	);

	always #2 us_clk = ~us_clk;

	task automatic stop_on_error;
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			stop_on_error();
		end
	endtask

	always @(posedge us_clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			stop_on_error();
		end
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output int value);
		int k;
		value = 0;
		for (k = 0; k < n; k++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr  = lfsr_next(lfsr);
		end
	endtask

	task automatic load_table;
		stim_table[0]  = {8'd5,   8'd125, 16'd1000, 8'd0}; // idle, reload
		stim_table[1]  = {8'd100, 8'd125, 16'd1000, 8'd2};
		stim_table[2]  = {8'd100, 8'd140, 16'd1200, 8'd0};
		stim_table[3]  = {8'd5,   8'd125, 16'd5740, 8'd1}; // park near 360
		stim_table[4]  = {8'd200, 8'd250, 16'd5750, 8'd3}; // wraps upward
		stim_table[5]  = {8'd200, 8'd250, 16'd5755, 8'd0};
		stim_table[6]  = {8'd200, 8'd0,   16'd5755, 8'd4};
		stim_table[7]  = {8'd200, 8'd0,   16'd20,   8'd0}; // wraps downward
		stim_table[8]  = {8'd200, 8'd0,   16'd30,   8'd2};
		stim_table[9]  = {8'd5,   8'd125, 16'd4000, 8'd0};
		stim_table[10] = {8'd100, 8'd125, 16'd1000, 8'd1}; // integral climbs
		stim_table[11] = {8'd100, 8'd125, 16'd1000, 8'd0};
		stim_table[12] = {8'd100, 8'd125, 16'd1000, 8'd5};
		stim_table[13] = {8'd100, 8'd125, 16'd1000, 8'd0};
		stim_table[14] = {8'd5,   8'd125, 16'd1500, 8'd2}; // clears integral
		stim_table[15] = {8'd150, 8'd125, 16'd4300, 8'd0};
		stim_table[16] = {8'd150, 8'd125, 16'd4300, 8'd1};
		stim_table[17] = {8'd150, 8'd125, 16'd4300, 8'd0};
		stim_table[18] = {8'd150, 8'd125, 16'd4300, 8'd3};
		stim_table[19] = {8'd9,   8'd125, 16'd2000, 8'd0}; // just below idle level
		stim_table[20] = {8'd10,  8'd130, 16'd2000, 8'd1}; // first flying value
	endtask

	task automatic present_row(input int idx);
		rx_valid  = 1'b1;
		throttle  = stim_table[idx][39:32];
		yaw_stick = stim_table[idx][31:24];
		imu_yaw   = stim_table[idx][23:8];
	endtask

	// heading, error and PI rules, one frame
	task automatic model_frame(input int idx, output int body, output int err,
		output int cmd);
		int thr;
		int stick;
		int imu;
		int sum;
		thr   = int'(stim_table[idx][39:32]);
		stick = int'(stim_table[idx][31:24]);
		imu   = int'($signed(stim_table[idx][23:8]));
		if (thr < int'(idle_throttle)) begin
			model_heading = imu * 4;
			model_integ   = 0;
			body          = imu;
			err           = 0;
		end else begin
			sum = model_heading + stick - int'(stick_center);
			if (sum > int'(track_360))
				sum -= int'(track_360);
			else if (sum < 0)
				sum += int'(track_360);
			model_heading = sum;
			body = model_heading >>> 2;
			if (body > int'(angle_270) && imu < int'(angle_90))
				err = (int'(angle_360) - body) + imu;
			else if (imu > int'(angle_270) && body < int'(angle_90))
				err = (imu - int'(angle_360)) - body;
			else
				err = body - imu;
			model_integ += err;
			if (model_integ > integ_limit)
				model_integ = integ_limit;
			else if (model_integ < -integ_limit)
				model_integ = -integ_limit;
		end
		cmd = (err >>> kp_shift) + (model_integ >>> ki_shift);
		if (cmd > rate_max)
			cmd = rate_max;
		else if (cmd < -rate_max)
			cmd = -rate_max;
	endtask

	task automatic check_outputs(input int body, input int err, input int cmd);
		check_value("body_yaw", body_yaw, 16'(body));
		check_value("yaw_error", yaw_error, 16'(err));
		check_value("yaw_rate_cmd", yaw_rate_cmd, 16'(cmd));
	endtask

	initial begin : stimulus
		int i;
		int extra;
		int stall;
		int edges;
		int exp_body;
		int exp_err;
		int exp_cmd;
		us_clk        = 1'b0;
		resetn        = 1'b0;
		rx_valid      = 1'b0;
		throttle      = '0;
		yaw_stick     = stick_center;
		imu_yaw       = '0;
		cmd_ready     = 1'b0;
		lfsr          = 32'h36c4_8f99;
		model_heading = 0;
		model_integ   = 0;
		load_table();

		repeat (5) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;
		check_value("rx_ready", 16'(rx_ready), 16'd1);
		check_value("cmd_valid", 16'(cmd_valid), 16'd0);
		check_outputs(0, 0, 0);

		present_row(0);
		for (i = 0; i < n_rows; i++) begin
			while (!rx_ready)
				@(negedge us_clk);
			@(negedge us_clk); // accept edge has passed
			rx_valid = 1'b0;
			model_frame(i, exp_body, exp_err, exp_cmd);
			edges = 0;
			while (!cmd_valid) begin
				check_value("rx_ready", 16'(rx_ready), 16'd0);
				@(negedge us_clk);
				edges++;
			end
			check_value("cmd_valid edges after accept", 16'(edges), 16'd6);
			check_outputs(exp_body, exp_err, exp_cmd);

			draw_bits(2, extra);
			stall = int'(stim_table[i][7:0]) + extra;
			if (i + 1 < n_rows)
				present_row(i + 1); // upstream waits on rx_ready
			repeat (stall) begin
				@(negedge us_clk);
				check_value("cmd_valid", 16'(cmd_valid), 16'd1);
				check_value("rx_ready", 16'(rx_ready), 16'd0);
				check_outputs(exp_body, exp_err, exp_cmd);
			end
			cmd_ready = 1'b1;
			@(negedge us_clk);
			cmd_ready = 1'b0;
			check_value("cmd_valid", 16'(cmd_valid), 16'd0);
			check_value("rx_ready", 16'(rx_ready), 16'd1);
		end

		repeat (3) @(negedge us_clk);
		check_value("cmd_valid", 16'(cmd_valid), 16'd0);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
logic/angle_pkg.sv
logic/receiver_pkg.sv
logic/control_frame_sequencer.sv
logic/yaw_angle_accumulator.sv
logic/yaw_rate_controller.sv
logic/yaw_control_top.sv
sim/yaw_control_tb.sv

//--- Bender.yml
package:
  name: yaw_control

sources:
  # packages
  - files:
      - logic/angle_pkg.sv
      - logic/receiver_pkg.sv

  # design
  - files:
      - logic/control_frame_sequencer.sv
      - logic/yaw_angle_accumulator.sv
      - logic/yaw_rate_controller.sv
      - logic/yaw_control_top.sv

  # testbench
  - target: test
    files:
      - sim/yaw_control_tb.sv
